// ==== verilog.f ====
+incdir+src
src/riscv_isa_pkg.sv
src/uop_pkg.sv
src/decode_ctrl_if.sv
src/instr_ctrl.sv
src/imm_gen.sv
src/uop_assemble.sv
src/decode_stage_buf.sv
src/decode_top.sv
dv/decode_assert.sv
dv/decode_checker.sv
dv/decode_tb.sv

// ==== Bender.yml ====
package:
  name: simt_decode

export_include_dirs:
  - src

sources:
  - src/riscv_isa_pkg.sv
  - src/uop_pkg.sv
  - src/decode_ctrl_if.sv
  - src/instr_ctrl.sv
  - src/imm_gen.sv
  - src/uop_assemble.sv
  - src/decode_stage_buf.sv
  - src/decode_top.sv
  - target: test
    files:
      - dv/decode_assert.sv
      - dv/decode_checker.sv
      - dv/decode_tb.sv

// ==== dv/decode_tb.sv ====
/*
 * Decode stage testbench
 * Stimulus table, random output stalls, flush, timeout and verdict
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decode_tb;
    import uop_pkg::*;

    localparam int MAX_ENTRIES = 48;

    logic clk, arst_n, flush, fetch_valid, fetch_ready, dec_valid, dec_ready;
    logic [`UUID_WIDTH-1:0]  fetch_uuid, dec_uuid;
    logic [`NW_WIDTH-1:0]    fetch_wid, dec_wid, sched_wid;
    logic [`NUM_THREADS-1:0] fetch_tmask, dec_tmask;
    logic [`XLEN-1:0]        fetch_pc, dec_pc, dec_imm;
    logic [31:0]             fetch_instr;
    ex_type_t                dec_ex_type;
    op_type_t                dec_op_type;
    op_mod_t                 dec_op_mod;
    logic dec_use_pc, dec_use_imm, dec_wb, dec_is_branch, sched_valid, sched_wstall;
    logic [4:0]              dec_rd, dec_rs1, dec_rs2;
    decode_uop_t             dec_obs;

    string       tname[MAX_ENTRIES];
    logic [31:0] tinstr[MAX_ENTRIES];
    decode_uop_t texp[MAX_ENTRIES];
    logic        twstall[MAX_ENTRIES];
    logic        tflush[MAX_ENTRIES];
    int          n_entries = 0, n_flush = 0, limit = 0, cycles = 0, seed = 1609, i;
    int          assert_fails = 0;

    decode_top decode_top_inst (.*);

    assign dec_obs = {dec_uuid, dec_wid, dec_tmask, dec_pc, dec_ex_type, dec_op_type, dec_op_mod,
                      dec_use_pc, dec_use_imm, dec_imm, dec_wb, dec_rd, dec_rs1, dec_rs2,
                      dec_is_branch};

    decode_checker decode_checker_inst (.clk(clk), .arst_n(arst_n), .flush(flush),
        .fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .dec_valid(dec_valid),
        .dec_ready(dec_ready), .dec_uop(dec_obs), .sched_valid(sched_valid),
        .sched_wid(sched_wid), .sched_wstall(sched_wstall));

    bind decode_stage_buf decode_assert decode_assert_inst (.clk(clk), .arst_n(arst_n),
        .flush(flush), .in_uop(in_uop), .out_valid(out_valid), .out_ready(out_ready),
        .out_uop(out_uop), .sched_valid(sched_valid));

    // fl = {wb, use_pc, use_imm, is_branch, wstall}
    task automatic add_entry(string nm, logic [31:0] ins, ex_type_t ex, logic [3:0] op,
                             logic [2:0] md, logic [31:0] imm, int rd, int rs1, int rs2,
                             logic [4:0] fl);
        decode_uop_t e;
        e.uuid  = `UUID_WIDTH'(n_entries + 8'h40);
        e.wid   = n_entries[`NW_WIDTH-1:0];
        e.tmask = `NUM_THREADS'(n_entries) ^ 4'hF;
        e.pc    = 32'h0000_1000 + 32'(4 * n_entries);
        e.ex_type = ex;
        e.op_type = op;
        e.op_mod  = md;
        e.imm     = imm;
        e.rd      = 5'(rd);
        e.rs1     = 5'(rs1);
        e.rs2     = 5'(rs2);
        {e.wb, e.use_pc, e.use_imm, e.is_branch} = fl[4:1];
        tname[n_entries]   = nm;
        tinstr[n_entries]  = ins;
        texp[n_entries]    = e;
        twstall[n_entries] = fl[0];
        tflush[n_entries]  = 1'b0;
        n_entries++;
    endtask

    task automatic mark_flushed();
        tflush[n_entries-1] = 1'b1;
        n_flush++;
    endtask

    task automatic build_table();
        add_entry("addi", 32'hFFB10093, EX_ALU, ALU_ADD, 0, 32'hFFFFFFFB, 1, 2, 0, 5'b10100);
        add_entry("srai", 32'h40725193, EX_ALU, ALU_SRA, 0, 32'd7, 3, 4, 0, 5'b10100);
        add_entry("slli_x0", 32'h00329013, EX_ALU, ALU_SLL, 0, 32'd3, 0, 5, 0, 5'b00100);
        add_entry("add", 32'h00838333, EX_ALU, ALU_ADD, 0, 32'd0, 6, 7, 8, 5'b10000);
        add_entry("sub", 32'h40B504B3, EX_ALU, ALU_SUB, 0, 32'd0, 9, 10, 11, 5'b10000);
        add_entry("sra", 32'h40E6D633, EX_ALU, ALU_SRA, 0, 32'd0, 12, 13, 14, 5'b10000);
        add_entry("and", 32'h011877B3, EX_ALU, ALU_AND, 0, 32'd0, 15, 16, 17, 5'b10000);
        add_entry("add_flushed", 32'h00838333, EX_ALU, ALU_ADD, 0, 32'd0, 6, 7, 8, 5'b10000);
        mark_flushed();
        add_entry("lui", 32'h123450B7, EX_ALU, ALU_LUI, 0, 32'h12345000, 1, 0, 0, 5'b10100);
        add_entry("auipc", 32'hFFFFF117, EX_ALU, ALU_AUIPC, 0, 32'hFFFFF000, 2, 0, 0, 5'b11100);
        add_entry("jal", 32'h008000EF, EX_ALU, BR_JAL, 1, 32'd8, 1, 0, 0, 5'b11111);
        add_entry("jalr_x0", 32'h00008067, EX_ALU, BR_JALR, 1, 32'd0, 0, 1, 0, 5'b00111);
        add_entry("beq", 32'hFE208EE3, EX_ALU, BR_EQ, 1, 32'hFFFFFFFC, 0, 1, 2, 5'b01111);
        add_entry("bne", 32'h00419863, EX_ALU, BR_NE, 1, 32'd16, 0, 3, 4, 5'b01111);
        add_entry("blt", 32'h0062C463, EX_ALU, BR_LT, 1, 32'd8, 0, 5, 6, 5'b01111);
        add_entry("bge", 32'h0020D463, EX_ALU, BR_GE, 1, 32'd8, 0, 1, 2, 5'b01111);
        add_entry("bltu", 32'h0020E463, EX_ALU, BR_LTU, 1, 32'd8, 0, 1, 2, 5'b01111);
        add_entry("bgeu", 32'h0020F463, EX_ALU, BR_GEU, 1, 32'd8, 0, 1, 2, 5'b01111);
        // LSU op is {store, funct3}
        add_entry("lw", 32'h00C32283, EX_LSU, 4'd2, 0, 32'd12, 5, 6, 0, 5'b10100);
        add_entry("lbu_x0", 32'h0000C003, EX_LSU, 4'd4, 0, 32'd0, 0, 1, 0, 5'b00100);
        add_entry("sw", 32'hFE742C23, EX_LSU, 4'd10, 0, 32'hFFFFFFF8, 0, 8, 7, 5'b00100);
        add_entry("fence", 32'h0FF0000F, EX_LSU, 4'd15, 0, 32'd0, 0, 0, 0, 5'b00000);
        add_entry("lui_flushed", 32'h123450B7, EX_ALU, ALU_LUI, 0, 32'h12345000, 1, 0, 0,
                  5'b10100);
        mark_flushed();
        add_entry("csrrw", 32'h300110F3, EX_SFU, SFU_CSRRW, 0, 32'h2300, 1, 2, 0, 5'b10001);
        add_entry("csrrsi", 32'h0012E1F3, EX_SFU, SFU_CSRRS, 0, 32'h5001, 3, 0, 0, 5'b10101);
        add_entry("csrrc", 32'hC002B273, EX_SFU, SFU_CSRRC, 0, 32'h5C00, 4, 5, 0, 5'b10001);
        add_entry("ecall", 32'h00000073, EX_ALU, BR_ECALL, 1, 32'd4, 0, 0, 0, 5'b01101);
        add_entry("ebreak", 32'h00100073, EX_ALU, BR_EBREAK, 1, 32'd4, 0, 0, 0, 5'b01101);
        add_entry("uret", 32'h00200073, EX_ALU, BR_URET, 1, 32'd4, 0, 0, 0, 5'b01101);
        add_entry("sret", 32'h10200073, EX_ALU, BR_SRET, 1, 32'd4, 0, 0, 0, 5'b01101);
        add_entry("mret", 32'h30200073, EX_ALU, BR_MRET, 1, 32'd4, 0, 0, 0, 5'b01101);
        add_entry("tmc", 32'h0000848B, EX_SFU, SFU_TMC, 0, 32'd0, 0, 1, 0, 5'b00001);
        add_entry("wspawn", 32'h0031100B, EX_SFU, SFU_WSPAWN, 0, 32'd0, 0, 2, 3, 5'b00001);
        add_entry("split", 32'h0003228B, EX_SFU, SFU_SPLIT, 0, 32'd0, 5, 6, 0, 5'b10001);
        add_entry("join", 32'h0003B00B, EX_SFU, SFU_JOIN, 0, 32'd0, 0, 7, 0, 5'b00001);
        add_entry("bar", 32'h0020C00B, EX_SFU, SFU_BAR, 0, 32'd0, 0, 1, 2, 5'b00001);
        add_entry("pred", 32'h0041D00B, EX_SFU, SFU_PRED, 0, 32'd0, 0, 3, 4, 5'b00001);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run length limit
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, decode stage stopped making progress", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_uuid = '0;
        fetch_wid = '0;
        fetch_tmask = '0;
        fetch_pc = '0;
        fetch_instr = '0;
        dec_ready = 1'b0;
        build_table();
        limit = 4 * n_entries + 50;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (i = 0; i < n_entries; i++) begin
            fetch_valid <= 1'b1;
            fetch_uuid  <= texp[i].uuid;
            fetch_wid   <= texp[i].wid;
            fetch_tmask <= texp[i].tmask;
            fetch_pc    <= texp[i].pc;
            fetch_instr <= tinstr[i];
            do begin
                dec_ready <= ($random(seed) & 3) != 0;
                @(posedge clk);
            end while (!fetch_ready);
            decode_checker_inst.record(tname[i], texp[i], twstall[i]);
            if (tflush[i]) begin   // Drop it while it sits in the register
                fetch_valid <= 1'b0;
                dec_ready   <= 1'b0;
                flush       <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end
        end
        fetch_valid <= 1'b0;
        dec_ready   <= 1'b1;
        while (decode_checker_inst.pending() > 0)
            @(posedge clk);
        @(posedge clk);
        decode_checker_inst.final_checks(n_flush);
        assert_fails = decode_top_inst.decode_stage_buf_inst.decode_assert_inst.fail_count;

        $display("Entries %0d, checks %0d, dropped %0d, errors %0d, assertion failures %0d",
                 n_entries, decode_checker_inst.checks, decode_checker_inst.dropped,
                 decode_checker_inst.errors, assert_fails);
        if (decode_checker_inst.errors == 0 && assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== dv/decode_checker.sv ====
/*
 * Scoreboard for the decode stage
 * Expected micro-op queue, output and scheduler comparison
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decode_checker (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  flush,
    input logic                  fetch_valid,
    input logic                  fetch_ready,
    input logic                  dec_valid,
    input logic                  dec_ready,
    input uop_pkg::decode_uop_t  dec_uop,
    input logic                  sched_valid,
    input logic [`NW_WIDTH-1:0]  sched_wid,
    input logic                  sched_wstall
);
    import uop_pkg::*;

    string       exp_name[$];
    decode_uop_t exp_uop[$];
    decode_uop_t held;
    logic        holding = 1'b0;
    int          errors = 0, checks = 0, accepted = 0, pulses = 0, dropped = 0;

    task automatic check_val(string tname, string field, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", tname, field, exp, act);
        end
    endtask

    // Called by the testbench on each accepted instruction
    task automatic record(string tname, decode_uop_t exp, logic wstall);
        accepted++;
        exp_name.push_back(tname);
        exp_uop.push_back(exp);
        check_val(tname, "sched_valid", 32'd1, 32'(sched_valid));
        check_val(tname, "sched_wid", 32'(exp.wid), 32'(sched_wid));
        check_val(tname, "sched_wstall", 32'(wstall), 32'(sched_wstall));
    endtask

    function automatic int pending();
        return exp_uop.size();
    endfunction

    task automatic compare_out(string tname, decode_uop_t e);
        check_val(tname, "uuid", 32'(e.uuid), 32'(dec_uop.uuid));
        check_val(tname, "wid", 32'(e.wid), 32'(dec_uop.wid));
        check_val(tname, "tmask", 32'(e.tmask), 32'(dec_uop.tmask));
        check_val(tname, "pc", e.pc, dec_uop.pc);
        check_val(tname, "ex_type", 32'(e.ex_type), 32'(dec_uop.ex_type));
        check_val(tname, "op_type", 32'(e.op_type), 32'(dec_uop.op_type));
        check_val(tname, "op_mod", 32'(e.op_mod), 32'(dec_uop.op_mod));
        check_val(tname, "use_pc", 32'(e.use_pc), 32'(dec_uop.use_pc));
        check_val(tname, "use_imm", 32'(e.use_imm), 32'(dec_uop.use_imm));
        check_val(tname, "imm", e.imm, dec_uop.imm);
        check_val(tname, "wb", 32'(e.wb), 32'(dec_uop.wb));
        check_val(tname, "rd", 32'(e.rd), 32'(dec_uop.rd));
        check_val(tname, "rs1", 32'(e.rs1), 32'(dec_uop.rs1));
        check_val(tname, "rs2", 32'(e.rs2), 32'(dec_uop.rs2));
        check_val(tname, "is_branch", 32'(e.is_branch), 32'(dec_uop.is_branch));
    endtask

    task automatic final_checks(int exp_dropped);
        if (pulses != accepted) begin
            errors++;
            $display("Scheduler saw %0d notices for %0d accepted instructions", pulses, accepted);
        end
        if (dropped != exp_dropped) begin
            errors++;
            $display("Flush dropped %0d instructions instead of %0d", dropped, exp_dropped);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (sched_valid)
                pulses++;
            if (sched_valid && !(fetch_valid && fetch_ready)) begin
                errors++;
                $display("sched_valid pulsed with no accepted instruction");
            end
            if (holding && (!dec_valid || dec_uop !== held)) begin
                errors++;
                $display("Decoded output changed while dec_ready was low");
            end
            if (dec_valid && dec_ready) begin
                if (exp_uop.size() == 0) begin
                    errors++;
                    $display("Output transfer with no instruction pending");
                end else begin
                    compare_out(exp_name.pop_front(), exp_uop.pop_front());
                end
            end else if (flush && dec_valid && exp_uop.size() > 0) begin
                void'(exp_name.pop_front());   // Held entry dropped
                void'(exp_uop.pop_front());
                dropped++;
            end
            holding = dec_valid && !dec_ready && !flush;
            held    = dec_uop;
        end
    end

endmodule

// ==== dv/decode_assert.sv ====
/*
 * Handshake and flush assertions for the decode pipeline register
 */
`timescale 1ns/10ps

module decode_assert (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 flush,
    input uop_pkg::decode_uop_t in_uop,
    input logic                 out_valid,
    input logic                 out_ready,
    input uop_pkg::decode_uop_t out_uop,
    input logic                 sched_valid
);

    int fail_count = 0;

    // Stalled output must hold
    hold_until_ready: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_uop))
        else begin
            $error("dec_valid or payload changed while stalled");
            fail_count++;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !out_valid)
        else begin
            $error("dec_valid still high after flush");
            fail_count++;
        end

    // Notice means the register takes this instruction
    sched_on_fire: assert property (@(posedge clk) disable iff (!arst_n)
        sched_valid |=> out_valid && out_uop == $past(in_uop))
        else begin
            $error("sched_valid without the instruction entering the register");
            fail_count++;
        end

endmodule

// ==== src/decode_top.sv ====
/*
 * Decode stage top level
 * Control decoder, immediate, micro-op packing, pipeline register
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decode_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     fetch_valid,
    output logic                     fetch_ready,
    input  logic [`UUID_WIDTH-1:0]   fetch_uuid,
    input  logic [`NW_WIDTH-1:0]     fetch_wid,
    input  logic [`NUM_THREADS-1:0]  fetch_tmask,
    input  logic [`XLEN-1:0]         fetch_pc,
    input  logic [31:0]              fetch_instr,
    output logic                     dec_valid,
    input  logic                     dec_ready,
    output logic [`UUID_WIDTH-1:0]   dec_uuid,
    output logic [`NW_WIDTH-1:0]     dec_wid,
    output logic [`NUM_THREADS-1:0]  dec_tmask,
    output logic [`XLEN-1:0]         dec_pc,
    output uop_pkg::ex_type_t        dec_ex_type,
    output uop_pkg::op_type_t        dec_op_type,
    output uop_pkg::op_mod_t         dec_op_mod,
    output logic                     dec_use_pc,
    output logic                     dec_use_imm,
    output logic [`XLEN-1:0]         dec_imm,
    output logic                     dec_wb,
    output logic [4:0]               dec_rd,
    output logic [4:0]               dec_rs1,
    output logic [4:0]               dec_rs2,
    output logic                     dec_is_branch,
    output logic                     sched_valid,
    output logic [`NW_WIDTH-1:0]     sched_wid,
    output logic                     sched_wstall
);
    import uop_pkg::*;

    decode_ctrl_if    ctrl_if ();
    logic [`XLEN-1:0] imm;
    decode_uop_t      uop_d, uop_q;

    instr_ctrl instr_ctrl_inst (.instr(fetch_instr), .ctrl(ctrl_if.ctrl));

    imm_gen imm_gen_inst (.instr(fetch_instr), .ctrl(ctrl_if.dp), .imm(imm));

    uop_assemble uop_assemble_inst (
        .instr (fetch_instr),
        .uuid  (fetch_uuid),
        .wid   (fetch_wid),
        .tmask (fetch_tmask),
        .pc    (fetch_pc),
        .ctrl  (ctrl_if.dp),
        .imm   (imm),
        .uop   (uop_d)
    );

    decode_stage_buf decode_stage_buf_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .in_valid     (fetch_valid),
        .in_ready     (fetch_ready),
        .in_uop       (uop_d),
        .ctrl         (ctrl_if.dp),
        .out_valid    (dec_valid),
        .out_ready    (dec_ready),
        .out_uop      (uop_q),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall)
    );

    assign dec_uuid      = uop_q.uuid;
    assign dec_wid       = uop_q.wid;
    assign dec_tmask     = uop_q.tmask;
    assign dec_pc        = uop_q.pc;
    assign dec_ex_type   = uop_q.ex_type;
    assign dec_op_type   = uop_q.op_type;
    assign dec_op_mod    = uop_q.op_mod;
    assign dec_use_pc    = uop_q.use_pc;
    assign dec_use_imm   = uop_q.use_imm;
    assign dec_imm       = uop_q.imm;
    assign dec_wb        = uop_q.wb;
    assign dec_rd        = uop_q.rd;
    assign dec_rs1       = uop_q.rs1;
    assign dec_rs2       = uop_q.rs2;
    assign dec_is_branch = uop_q.is_branch;

endmodule

// ==== src/decode_stage_buf.sv ====
/*
 * One-entry valid/ready pipeline register with flush
 * Scheduler stall notice on input transfer
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decode_stage_buf (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  uop_pkg::decode_uop_t     in_uop,
    decode_ctrl_if.dp                ctrl,
    output logic                     out_valid,
    input  logic                     out_ready,
    output uop_pkg::decode_uop_t     out_uop,
    output logic                     sched_valid,
    output logic [`NW_WIDTH-1:0]     sched_wid,
    output logic                     sched_wstall
);

    logic in_fire;

    assign in_ready = (~out_valid | out_ready) & ~flush;
    assign in_fire  = in_valid & in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_uop <= in_uop;
        end
    end

    // Warp scheduler notice
    assign sched_valid  = in_fire;
    assign sched_wid    = in_uop.wid;
    assign sched_wstall = ctrl.is_wstall;

endmodule

// ==== src/uop_assemble.sv ====
/*
 * Register index masking, write-back flag, micro-op packing
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module uop_assemble (
    input  logic [31:0]             instr,
    input  logic [`UUID_WIDTH-1:0]  uuid,
    input  logic [`NW_WIDTH-1:0]    wid,
    input  logic [`NUM_THREADS-1:0] tmask,
    input  logic [`XLEN-1:0]        pc,
    decode_ctrl_if.dp               ctrl,
    input  logic [`XLEN-1:0]        imm,
    output uop_pkg::decode_uop_t    uop
);
    import riscv_isa_pkg::*;

    logic [4:0] rd, rs1, rs2;

    assign rd  = ctrl.use_rd  ? instr[RD_LSB  +: 5] : 5'd0;
    assign rs1 = ctrl.use_rs1 ? instr[RS1_LSB +: 5] : 5'd0;
    assign rs2 = ctrl.use_rs2 ? instr[RS2_LSB +: 5] : 5'd0;

    always_comb begin
        uop.uuid      = uuid;
        uop.wid       = wid;
        uop.tmask     = tmask;
        uop.pc        = pc;
        uop.ex_type   = ctrl.ex_type;
        uop.op_type   = ctrl.op_type;
        uop.op_mod    = ctrl.op_mod;
        uop.use_pc    = ctrl.use_pc;
        uop.use_imm   = ctrl.use_imm;
        uop.imm       = imm;
        uop.wb        = ctrl.use_rd && (rd != 5'd0);   // x0 never written
        uop.rd        = rd;
        uop.rs1       = rs1;
        uop.rs2       = rs2;
        uop.is_branch = ctrl.is_branch;
    end

endmodule

// ==== src/imm_gen.sv ====
/*
 * Immediate generator, sign extended per format
 */
`timescale 1ns/10ps
`include "decode_cfg.svh"

module imm_gen (
    input  logic [31:0]        instr,
    decode_ctrl_if.dp          ctrl,
    output logic [`XLEN-1:0]   imm
);
    import riscv_isa_pkg::*;

    logic        is_shift;
    logic [11:0] i_imm, s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    // Only OP-IMM shifts carry a shamt
    assign is_shift = (instr[OPC_LSB +: 7] == OPC_OP_IMM) && (instr[F3_LSB +: 2] == 2'b01);

    assign i_imm = is_shift ? {7'b0, instr[24:20]} : instr[31:20];
    assign s_imm = {instr[F7_LSB +: 7], instr[RD_LSB +: 5]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (ctrl.imm_sel)
            IMM_I:      imm = {{(`XLEN-12){i_imm[11]}}, i_imm};
            IMM_S:      imm = {{(`XLEN-12){s_imm[11]}}, s_imm};
            IMM_B:      imm = {{(`XLEN-13){b_imm[12]}}, b_imm};
            IMM_U:      imm = {instr[31:12], 12'b0};
            IMM_J:      imm = {{(`XLEN-21){j_imm[20]}}, j_imm};
            IMM_CSR:    imm = {{(`XLEN-17){1'b0}}, instr[RS1_LSB +: 5], instr[31:20]};
            IMM_CONST4: imm = `XLEN'd4;
            default:    imm = '0;
        endcase
    end

endmodule

// ==== src/instr_ctrl.sv ====
/*
 * Opcode and function-field decoder
 * ALU, branch, system and GPU op tables
 */
`timescale 1ns/10ps

module instr_ctrl (
    input  logic [31:0]   instr,
    decode_ctrl_if.ctrl   ctrl
);
    import riscv_isa_pkg::*;
    import uop_pkg::*;

    opcode_t     opcode;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] u12;
    alu_op_e     alu_op;
    br_op_e      br_op;
    br_op_e      sys_op;
    sfu_op_e     gpu_op;

    assign opcode = opcode_t'(instr[OPC_LSB +: 7]);
    assign f3     = instr[F3_LSB +: 3];
    assign f7     = instr[F7_LSB +: 7];
    assign u12    = instr[RS2_LSB +: 12];

    always_comb begin
        case (f3)
            3'h0: alu_op = (opcode == OPC_OP && f7[5]) ? ALU_SUB : ALU_ADD;
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = f7[5] ? ALU_SRA : ALU_SRL;
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase

        case (f3)
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: br_op = BR_EQ;
        endcase

        case (u12)
            12'h001: sys_op = BR_EBREAK;
            12'h002: sys_op = BR_URET;
            12'h102: sys_op = BR_SRET;
            12'h302: sys_op = BR_MRET;
            default: sys_op = BR_ECALL;
        endcase

        case (f3)
            3'h0: gpu_op = SFU_TMC;
            3'h1: gpu_op = SFU_WSPAWN;
            3'h2: gpu_op = SFU_SPLIT;
            3'h3: gpu_op = SFU_JOIN;
            3'h4: gpu_op = SFU_BAR;
            default: gpu_op = SFU_PRED;
        endcase
    end

    always_comb begin
        ctrl.ex_type   = EX_ALU;
        ctrl.op_type   = '0;
        ctrl.op_mod    = '0;
        ctrl.use_pc    = 1'b0;
        ctrl.use_imm   = 1'b0;
        ctrl.use_rd    = 1'b0;
        ctrl.use_rs1   = 1'b0;
        ctrl.use_rs2   = 1'b0;
        ctrl.imm_sel   = IMM_NONE;
        ctrl.is_wstall = 1'b0;
        ctrl.is_branch = 1'b0;

        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                ctrl.op_type = alu_op;
                ctrl.use_rd  = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = (opcode == OPC_OP);
                ctrl.use_imm = (opcode == OPC_OP_IMM);
                ctrl.imm_sel = (opcode == OPC_OP_IMM) ? IMM_I : IMM_NONE;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.op_type = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                ctrl.use_pc  = (opcode == OPC_AUIPC);
                ctrl.use_rd  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm_sel = IMM_U;
            end
            OPC_JAL, OPC_JALR, OPC_BRANCH: begin
                ctrl.op_mod[MOD_BR] = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.is_wstall = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.use_pc    = (opcode != OPC_JALR);   // JALR is rs1 relative
                ctrl.use_rd    = (opcode != OPC_BRANCH);
                ctrl.use_rs1   = (opcode != OPC_JAL);
                ctrl.use_rs2   = (opcode == OPC_BRANCH);
                case (opcode)
                    OPC_JAL: begin
                        ctrl.op_type = BR_JAL;
                        ctrl.imm_sel = IMM_J;
                    end
                    OPC_JALR: begin
                        ctrl.op_type = BR_JALR;
                        ctrl.imm_sel = IMM_I;
                    end
                    default: begin
                        ctrl.op_type = br_op;
                        ctrl.imm_sel = IMM_B;
                    end
                endcase
            end
            OPC_LOAD, OPC_STORE: begin
                ctrl.ex_type = EX_LSU;
                ctrl.op_type = lsu_op(opcode == OPC_STORE, f3);
                ctrl.use_imm = 1'b1;
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rd  = (opcode == OPC_LOAD);
                ctrl.use_rs2 = (opcode == OPC_STORE);
                ctrl.imm_sel = (opcode == OPC_LOAD) ? IMM_I : IMM_S;
            end
            OPC_FENCE: begin
                ctrl.ex_type = EX_LSU;
                ctrl.op_type = LSU_FENCE;
            end
            OPC_SYSTEM: begin
                ctrl.use_rd    = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.is_wstall = 1'b1;
                if (f3[1:0] != 2'b00) begin   // CSR access
                    ctrl.ex_type = EX_SFU;
                    ctrl.op_type = op_type_t'(SFU_CSRRW) + op_type_t'(f3[1:0] - 2'd1);
                    ctrl.use_imm = f3[2];
                    ctrl.use_rs1 = ~f3[2];
                    ctrl.imm_sel = IMM_CSR;
                end else begin
                    ctrl.op_type = sys_op;
                    ctrl.op_mod[MOD_BR] = 1'b1;
                    ctrl.use_pc  = 1'b1;
                    ctrl.imm_sel = IMM_CONST4;   // Return address PC + 4
                end
            end
            OPC_EXT1: begin
                if (f7 == 7'h00 && f3 <= 3'h5) begin
                    ctrl.ex_type   = EX_SFU;
                    ctrl.op_type   = gpu_op;
                    ctrl.is_wstall = 1'b1;
                    ctrl.use_rs1   = 1'b1;
                    ctrl.use_rd    = (gpu_op == SFU_SPLIT);
                    ctrl.use_rs2   = (gpu_op == SFU_WSPAWN || gpu_op == SFU_BAR ||
                                      gpu_op == SFU_PRED);
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/decode_ctrl_if.sv ====
/*
 * Control word from the opcode decoder to the datapath
 */
`timescale 1ns/10ps

interface decode_ctrl_if;
    import riscv_isa_pkg::*;
    import uop_pkg::*;

    ex_type_t ex_type;
    op_type_t op_type;
    op_mod_t  op_mod;
    logic     use_pc, use_imm;
    logic     use_rd, use_rs1, use_rs2;
    imm_sel_t imm_sel;
    logic     is_wstall;
    logic     is_branch;

    modport ctrl (output ex_type, op_type, op_mod, use_pc, use_imm, use_rd, use_rs1,
                  use_rs2, imm_sel, is_wstall, is_branch);
    modport dp   (input  ex_type, op_type, op_mod, use_pc, use_imm, use_rd, use_rs1,
                  use_rs2, imm_sel, is_wstall, is_branch);
endinterface

// ==== src/uop_pkg.sv ====
/*
 * Decoded micro-op definitions
 * Unit and operation encodings, micro-op struct
 */
`include "decode_cfg.svh"

package uop_pkg;

    typedef enum logic [1:0] {EX_ALU, EX_LSU, EX_SFU} ex_type_t;

    typedef logic [3:0] op_type_t;
    typedef logic [2:0] op_mod_t;

    localparam int MOD_BR = 0;   // op_mod bit for branch-unit ops

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_BAR, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // LSU op is store bit then funct3
    localparam op_type_t LSU_FENCE = 4'd15;

    function automatic op_type_t lsu_op(input logic store, input logic [2:0] f3);
        return {store, f3};
    endfunction

    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [`NW_WIDTH-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        ex_type_t                ex_type;
        op_type_t                op_type;
        op_mod_t                 op_mod;
        logic                    use_pc;
        logic                    use_imm;
        logic [`XLEN-1:0]        imm;
        logic                    wb;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic                    is_branch;
    } decode_uop_t;

endpackage

// ==== src/riscv_isa_pkg.sv ====
/*
 * RV32 instruction set encodings
 * Major opcodes, immediate formats, field positions
 */
package riscv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'h03,
        OPC_EXT1   = 7'h0B,    // GPU warp control
        OPC_FENCE  = 7'h0F,
        OPC_OP_IMM = 7'h13,
        OPC_AUIPC  = 7'h17,
        OPC_STORE  = 7'h23,
        OPC_OP     = 7'h33,
        OPC_LUI    = 7'h37,
        OPC_BRANCH = 7'h63,
        OPC_JALR   = 7'h67,
        OPC_JAL    = 7'h6F,
        OPC_SYSTEM = 7'h73
    } opcode_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_CONST4
    } imm_sel_t;

    // Field positions within the instruction word
    localparam int OPC_LSB = 0;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

endpackage

// ==== src/decode_cfg.svh ====
/*
 * Core configuration macros for the decode stage
 * Data width, warp and thread counts, uuid width
 */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define XLEN        32
`define NUM_WARPS   4
`define NUM_THREADS 4
`define UUID_WIDTH  8
`define NW_WIDTH    $clog2(`NUM_WARPS)

`endif
